// File: rtl/tcp_tx_params.svh
`ifndef TCP_TX_PARAMS_SVH
`define TCP_TX_PARAMS_SVH

// ------------------------------
// noc flit and mesh
// ------------------------------
`define NOC_DATA_WIDTH      64
`define XY_WIDTH            4
`define NOC_FBITS_WIDTH     4   // final-port selector

`define MSG_SRC_X_WIDTH     4
`define MSG_SRC_Y_WIDTH     4
`define MSG_TYPE_WIDTH      8
`define MSG_LEN_WIDTH       4   // no payload flits follow, always zero here

// ------------------------------
// flows and descriptors
// ------------------------------
`define FLOWID_W            4
`define NUM_FLOWS           16  // 2**FLOWID_W, poller relies on the wrap

// payload pointer, one more bit is carried for wrap
`define TX_PAYLOAD_PTR_W    12
`define TX_LEN_W            8   // descriptor length field

`endif

// File: rtl/tcp_tx_pkg.sv
`default_nettype none

`include "tcp_tx_params.svh"

package tcp_tx_pkg;

    // ------------------------------
    // send descriptor
    // ------------------------------
    typedef struct packed {
        logic [`TX_PAYLOAD_PTR_W:0]     base_ptr;   // tail pointer plus wrap bit
        logic [`TX_LEN_W-1:0]           len;
        logic [`XY_WIDTH-1:0]           dst_x;
        logic [`XY_WIDTH-1:0]           dst_y;
        logic [`NOC_FBITS_WIDTH-1:0]    dst_fbits;
    } tx_desc_t;

    // poller to noc interface
    typedef struct packed {
        logic [`FLOWID_W-1:0]   flowid;
        tx_desc_t               desc;
    } msg_req_t;

    // ------------------------------
    // noc header flit
    // ------------------------------
    typedef struct packed {
        logic [`XY_WIDTH-1:0]           dst_x_coord;
        logic [`XY_WIDTH-1:0]           dst_y_coord;
        logic [`NOC_FBITS_WIDTH-1:0]    dst_fbits;
        logic [`MSG_LEN_WIDTH-1:0]      msg_len;
        logic [`MSG_TYPE_WIDTH-1:0]     msg_type;
        logic [`MSG_SRC_X_WIDTH-1:0]    src_x_coord;
        logic [`MSG_SRC_Y_WIDTH-1:0]    src_y_coord;
        logic [`NOC_FBITS_WIDTH-1:0]    src_fbits;
    } noc_hdr_core_t;

    // unused low bits of the flit
    localparam int HDR_PAD_W = `NOC_DATA_WIDTH - $bits(noc_hdr_core_t) - `FLOWID_W
                             - (`TX_PAYLOAD_PTR_W + 1) - `TX_LEN_W;

    typedef struct packed {
        noc_hdr_core_t                  core;
        logic [`FLOWID_W-1:0]           flowid;
        logic [`TX_PAYLOAD_PTR_W:0]     tail_ptr;
        logic [`TX_LEN_W-1:0]           length;
        logic [HDR_PAD_W-1:0]           padding;    // zero
    } tcp_noc_hdr_flit;

    localparam logic [`MSG_TYPE_WIDTH-1:0]  TCP_TX_MSG_RESP         = 8'h2c;
    localparam logic [`NOC_FBITS_WIDTH-1:0] TCP_TX_APP_PTR_IF_FBITS = 4'h3;

endpackage

`default_nettype wire

// File: rtl/tcp_tx_flow_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcp_tx_params.svh"

module tcp_tx_flow_table (
    input  logic                        clk,
    input  logic                        rst,

    // software write port
    input  logic                        wr_val,
    input  logic [`FLOWID_W-1:0]        wr_flowid,
    input  tcp_tx_pkg::tx_desc_t        wr_desc,

    // clear from the poller
    input  logic                        clr_val,
    input  logic [`FLOWID_W-1:0]        clr_flowid,

    // read port
    input  logic [`FLOWID_W-1:0]        rd_flowid,
    output tcp_tx_pkg::tx_desc_t        rd_desc,

    output logic [`NUM_FLOWS-1:0]       pending
);

    tcp_tx_pkg::tx_desc_t   desc_mem [`NUM_FLOWS];
    logic [`NUM_FLOWS-1:0]  pending_reg;
    logic [`NUM_FLOWS-1:0]  pending_next;

    assign pending = pending_reg;
    assign rd_desc = desc_mem[rd_flowid];   // async read

    // ------------------------------
    // descriptor storage
    // ------------------------------
    always_ff @(posedge clk) begin
        if (wr_val) begin
            desc_mem[wr_flowid] <= wr_desc; // replaces any older descriptor
        end
    end

    // ------------------------------
    // pending bits
    // ------------------------------
    always_comb begin
        pending_next = pending_reg;
        if (clr_val) begin
            pending_next[clr_flowid] = 1'b0;
        end
        // write after clear, so a same-cycle write keeps the flow pending
        if (wr_val) begin
            pending_next[wr_flowid] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending_reg <= '0;
        end else begin
            pending_reg <= pending_next;
        end
    end

endmodule

`default_nettype wire

// File: rtl/tcp_tx_poller.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcp_tx_params.svh"

module tcp_tx_poller (
    input  logic                        clk,
    input  logic                        rst,

    // flow table
    input  logic [`NUM_FLOWS-1:0]       pending,
    output logic [`FLOWID_W-1:0]        rd_flowid,
    input  tcp_tx_pkg::tx_desc_t        rd_desc,
    output logic                        clr_val,
    output logic [`FLOWID_W-1:0]        clr_flowid,

    // request to the noc interface
    output logic                        req_val,
    output tcp_tx_pkg::msg_req_t        req,
    input  logic                        req_rdy
);

    logic [`FLOWID_W-1:0]   last_grant;
    logic [`FLOWID_W-1:0]   sel_flowid;
    logic [`FLOWID_W-1:0]   probe;
    logic                   found;
    logic                   xfer;

    // ------------------------------
    // round-robin search
    // ------------------------------
    // start just after the last grant, the last grant itself is checked last
    always_comb begin
        sel_flowid = last_grant;
        found = 1'b0;
        probe = '0;
        for (int i = 1; i <= `NUM_FLOWS; i++) begin
            probe = last_grant + i[`FLOWID_W-1:0];  // wraps at NUM_FLOWS
            if (!found && pending[probe]) begin
                sel_flowid = probe;
                found = 1'b1;
            end
        end
    end

    assign rd_flowid = sel_flowid;

    assign req_val = found;
    assign req.flowid = sel_flowid;
    assign req.desc = rd_desc;

    assign xfer = req_val & req_rdy;

    // drop the pending bit of the flow just handed over
    assign clr_val = xfer;
    assign clr_flowid = sel_flowid;

    // ------------------------------
    // grant pointer
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            last_grant <= '1;   // so flow 0 is looked at first
        end else if (xfer) begin
            last_grant <= sel_flowid;
        end
    end

endmodule

`default_nettype wire

// File: rtl/tcp_tx_msg_noc_if_out_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_tx_msg_noc_if_out_ctrl (
    input  logic    clk,
    input  logic    rst,

    // request from the poller
    input  logic    req_val,
    output logic    req_rdy,

    // to the datapath
    output logic    store_inputs,

    // noc output
    output logic    noc_val,
    input  logic    noc_rdy
);

    typedef enum logic {
        IDLE,
        SEND
    } state_t;

    state_t state_reg;
    state_t state_next;

    assign req_rdy = (state_reg == IDLE);
    assign noc_val = (state_reg == SEND);

    assign store_inputs = req_rdy & req_val;    // one cycle, on the transfer

    // ------------------------------
    // next state
    // ------------------------------
    always_comb begin
        state_next = state_reg;
        case (state_reg)
            IDLE: begin
                if (req_val) begin
                    state_next = SEND;
                end
            end
            SEND: begin
                // flit held until the noc takes it
                if (noc_rdy) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= IDLE;
        end else begin
            state_reg <= state_next;
        end
    end

endmodule

`default_nettype wire

// File: rtl/tcp_tx_msg_noc_if_out_datap.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcp_tx_params.svh"

module tcp_tx_msg_noc_if_out_datap #(
    parameter int SRC_X = 0,
    parameter int SRC_Y = 0
) (
    input  logic                        clk,
    input  logic                        rst,

    input  tcp_tx_pkg::msg_req_t        req,
    input  logic                        store_inputs,

    output logic [`NOC_DATA_WIDTH-1:0]  noc_data
);

    tcp_tx_pkg::msg_req_t       req_reg;
    tcp_tx_pkg::msg_req_t       req_next;
    tcp_tx_pkg::tcp_noc_hdr_flit hdr_flit;

    assign noc_data = hdr_flit;

    // ------------------------------
    // request registers
    // ------------------------------
    always_comb begin
        if (store_inputs) begin
            req_next = req;
        end else begin
            req_next = req_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req_reg <= '0;
        end else begin
            req_reg <= req_next;
        end
    end

    // ------------------------------
    // header flit
    // ------------------------------
    always_comb begin
        hdr_flit = '0;

        hdr_flit.core.dst_x_coord = req_reg.desc.dst_x;
        hdr_flit.core.dst_y_coord = req_reg.desc.dst_y;
        hdr_flit.core.dst_fbits = req_reg.desc.dst_fbits;
        hdr_flit.core.msg_len = '0;     // header only
        hdr_flit.core.msg_type = tcp_tx_pkg::TCP_TX_MSG_RESP;
        hdr_flit.core.src_x_coord = SRC_X[`MSG_SRC_X_WIDTH-1:0];
        hdr_flit.core.src_y_coord = SRC_Y[`MSG_SRC_Y_WIDTH-1:0];
        hdr_flit.core.src_fbits = tcp_tx_pkg::TCP_TX_APP_PTR_IF_FBITS;

        hdr_flit.flowid = req_reg.flowid;
        hdr_flit.tail_ptr = req_reg.desc.base_ptr;
        hdr_flit.length = req_reg.desc.len;
    end

endmodule

`default_nettype wire

// File: rtl/tcp_tx_msg_tile.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcp_tx_params.svh"

module tcp_tx_msg_tile #(
    parameter int SRC_X = 0,
    parameter int SRC_Y = 0
) (
    input  logic                        clk,
    input  logic                        rst,

    // descriptor writes
    input  logic                        wr_val,
    input  logic [`FLOWID_W-1:0]        wr_flowid,
    input  tcp_tx_pkg::tx_desc_t        wr_desc,

    // noc output
    output logic                        noc_val,
    output logic [`NOC_DATA_WIDTH-1:0]  noc_data,
    input  logic                        noc_rdy
);

    logic [`NUM_FLOWS-1:0]  pending;
    logic [`FLOWID_W-1:0]   rd_flowid;
    tcp_tx_pkg::tx_desc_t   rd_desc;
    logic                   clr_val;
    logic [`FLOWID_W-1:0]   clr_flowid;

    logic                   req_val;
    logic                   req_rdy;
    tcp_tx_pkg::msg_req_t   req;
    logic                   store_inputs;

    // ------------------------------
    // flow side
    // ------------------------------
    tcp_tx_flow_table flow_table (
        .clk        (clk),
        .rst        (rst),
        .wr_val     (wr_val),
        .wr_flowid  (wr_flowid),
        .wr_desc    (wr_desc),
        .clr_val    (clr_val),
        .clr_flowid (clr_flowid),
        .rd_flowid  (rd_flowid),
        .rd_desc    (rd_desc),
        .pending    (pending)
    );

    tcp_tx_poller poller (
        .clk        (clk),
        .rst        (rst),
        .pending    (pending),
        .rd_flowid  (rd_flowid),
        .rd_desc    (rd_desc),
        .clr_val    (clr_val),
        .clr_flowid (clr_flowid),
        .req_val    (req_val),
        .req        (req),
        .req_rdy    (req_rdy)
    );

    // ------------------------------
    // noc interface
    // ------------------------------
    tcp_tx_msg_noc_if_out_ctrl noc_if_ctrl (
        .clk            (clk),
        .rst            (rst),
        .req_val        (req_val),
        .req_rdy        (req_rdy),
        .store_inputs   (store_inputs),
        .noc_val        (noc_val),
        .noc_rdy        (noc_rdy)
    );

    tcp_tx_msg_noc_if_out_datap #(
        .SRC_X  (SRC_X),
        .SRC_Y  (SRC_Y)
    ) noc_if_datap (
        .clk            (clk),
        .rst            (rst),
        .req            (req),
        .store_inputs   (store_inputs),
        .noc_data       (noc_data)
    );

endmodule

`default_nettype wire

// File: tb/tcp_tx_msg_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcp_tx_params.svh"

module tcp_tx_msg_checker (
    input  logic                        clk,
    input  logic                        rst,

    // dut noc output
    input  logic                        noc_val,
    input  logic [`NOC_DATA_WIDTH-1:0]  noc_data,
    input  logic                        noc_rdy,

    // expected flits from the testbench
    input  logic                        exp_wr,
    input  logic [`FLOWID_W-1:0]        exp_flowid,
    input  logic [`NOC_DATA_WIDTH-1:0]  exp_flit,

    output int                          errors,
    output int                          flits,
    output int                          outstanding
);

    logic [`NOC_DATA_WIDTH-1:0]     exp_mem [`NUM_FLOWS];
    logic [`NUM_FLOWS-1:0]          exp_valid;
    logic                           held;       // flit offered but not taken
    logic [`NOC_DATA_WIDTH-1:0]     held_data;
    tcp_tx_pkg::tcp_noc_hdr_flit    flit;
    logic [`FLOWID_W-1:0]           fid;

    assign flit = noc_data;
    assign fid = flit.flowid;
    assign outstanding = $countones(exp_valid);

    // ------------------------------
    // compare on every accepted flit
    // ------------------------------
    always @(posedge clk) begin
        if (rst) begin
            exp_valid <= '0;
            held <= 1'b0;
            held_data <= '0;
            errors = 0;
            flits = 0;
        end else begin
            if (held && !noc_val) begin
                $display("%0t ns: noc_val dropped before the flit was taken", $time);
                errors++;
            end else if (held && noc_data != held_data) begin
                $display("ERROR %0t ns: noc_data got %h expected %h",
                         $time, noc_data, held_data);
                errors++;
            end
            if (noc_val && noc_rdy) begin
                flits++;
                if (!exp_valid[fid]) begin
                    $display("%0t ns: flit for flow %0d arrived with nothing expected",
                             $time, fid);
                    errors++;
                end else if (noc_data != exp_mem[fid]) begin
                    $display("ERROR %0t ns: noc_data got %h expected %h",
                             $time, noc_data, exp_mem[fid]);
                    errors++;
                end
                exp_valid[fid] <= 1'b0;
            end
            // a new write to the same flow lands after the clear
            if (exp_wr) begin
                exp_mem[exp_flowid] <= exp_flit;
                exp_valid[exp_flowid] <= 1'b1;
            end
            held <= noc_val && !noc_rdy;
            held_data <= noc_data;
        end
    end

endmodule

`default_nettype wire

// File: tb/tcp_tx_msg_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcp_tx_params.svh"

module tcp_tx_msg_tb;

    localparam int SRC_X = 2;
    localparam int SRC_Y = 3;
    localparam int TOTAL_WRITES = 1 + 2 * `NUM_FLOWS + 3;
    localparam int MAX_CYCLES = TOTAL_WRITES * (`NUM_FLOWS + 8) + 8 + 300;
    localparam int DRAIN_LIMIT = `NUM_FLOWS * (`NUM_FLOWS + 8);

    logic                       clk;
    logic                       rst;
    logic                       wr_val;
    logic [`FLOWID_W-1:0]       wr_flowid;
    tcp_tx_pkg::tx_desc_t       wr_desc;
    logic                       noc_val;
    logic [`NOC_DATA_WIDTH-1:0] noc_data;
    logic                       noc_rdy;

    logic                       exp_wr;
    logic [`FLOWID_W-1:0]       exp_flowid;
    logic [`NOC_DATA_WIDTH-1:0] exp_flit;
    int                         chk_errors;
    int                         chk_flits;
    int                         outstanding;

    logic [31:0]                lfsr;
    logic                       rdy_random;
    int                         fails;
    int                         cycles = 0;

    tcp_tx_msg_tile #(
        .SRC_X  (SRC_X),
        .SRC_Y  (SRC_Y)
    ) uut (
        .clk        (clk),
        .rst        (rst),
        .wr_val     (wr_val),
        .wr_flowid  (wr_flowid),
        .wr_desc    (wr_desc),
        .noc_val    (noc_val),
        .noc_data   (noc_data),
        .noc_rdy    (noc_rdy)
    );

    tcp_tx_msg_checker flit_check (
        .clk        (clk),
        .rst        (rst),
        .noc_val    (noc_val),
        .noc_data   (noc_data),
        .noc_rdy    (noc_rdy),
        .exp_wr     (exp_wr),
        .exp_flowid (exp_flowid),
        .exp_flit   (exp_flit),
        .errors     (chk_errors),
        .flits      (chk_flits),
        .outstanding(outstanding)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------
    // random bits and reference
    // ------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // header core then flowid, tail pointer and length over a zero fill
    function automatic logic [`NOC_DATA_WIDTH-1:0] expected_flit(
        input logic [`FLOWID_W-1:0] flowid,
        input tcp_tx_pkg::tx_desc_t d
    );
        return {d.dst_x, d.dst_y, d.dst_fbits, {`MSG_LEN_WIDTH{1'b0}},
                tcp_tx_pkg::TCP_TX_MSG_RESP,
                `MSG_SRC_X_WIDTH'(SRC_X), `MSG_SRC_Y_WIDTH'(SRC_Y),
                tcp_tx_pkg::TCP_TX_APP_PTR_IF_FBITS,
                flowid, d.base_ptr, d.len, {tcp_tx_pkg::HDR_PAD_W{1'b0}}};
    endfunction

    function automatic int total_errors();
        return fails + chk_errors;
    endfunction

    // ------------------------------
    // stimulus tasks
    // ------------------------------
    task automatic next_edge();
        logic [31:0] b;
        @(posedge clk);
        wr_val <= 1'b0;
        exp_wr <= 1'b0;
        if (rdy_random) begin
            take_bits(1, b);
            noc_rdy <= b[0];
        end
    endtask

    task automatic write_flow(input logic [`FLOWID_W-1:0] flowid);
        tcp_tx_pkg::tx_desc_t d;
        logic [31:0] v;
        take_bits(`TX_PAYLOAD_PTR_W + 1, v);
        d.base_ptr = v[`TX_PAYLOAD_PTR_W:0];
        take_bits(`TX_LEN_W, v);
        d.len = v[`TX_LEN_W-1:0];
        take_bits(`XY_WIDTH, v);
        d.dst_x = v[`XY_WIDTH-1:0];
        take_bits(`XY_WIDTH, v);
        d.dst_y = v[`XY_WIDTH-1:0];
        take_bits(`NOC_FBITS_WIDTH, v);
        d.dst_fbits = v[`NOC_FBITS_WIDTH-1:0];
        next_edge();
        wr_val <= 1'b1;
        wr_flowid <= flowid;
        wr_desc <= d;
        exp_wr <= 1'b1;     // overwrites any older entry
        exp_flowid <= flowid;
        exp_flit <= expected_flit(flowid, d);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        do begin
            next_edge();
            @(negedge clk);
            waited++;
        end while (outstanding != 0 && waited < DRAIN_LIMIT);
        rdy_random = 1'b0;
        next_edge();
        noc_rdy <= 1'b1;
        repeat (20) next_edge();    // room for a duplicate to show up
        @(negedge clk);
    endtask

    task automatic finish_test(input int num, input string name, input int flits_before,
                               input int errs_before, input int flits_wanted);
        int got;
        got = chk_flits - flits_before;
        if (got != flits_wanted) begin
            $display("test %0d: wanted %0d flits but %0d came out", num, flits_wanted, got);
            fails++;
        end
        if (outstanding != 0) begin
            $display("test %0d: %0d flows never produced a flit", num, outstanding);
            fails++;
        end
        $display("test %0d %s: %0d errors", num, name, total_errors() - errs_before);
    endtask

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        int flits_before;
        int errs_before;
        rst = 1'b1;
        wr_val = 1'b0;
        wr_flowid = '0;
        wr_desc = '0;
        noc_rdy = 1'b1;
        exp_wr = 1'b0;
        exp_flowid = '0;
        exp_flit = '0;
        lfsr = 32'hd28c3bab;
        rdy_random = 1'b0;
        fails = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        flits_before = chk_flits;
        errs_before = total_errors();
        repeat (20) begin
            @(negedge clk);
            if (noc_val) begin
                $display("ERROR %0t ns: noc_val got %b expected %b", $time, noc_val, 1'b0);
                fails++;
            end
        end
        finish_test(1, "idle after reset", flits_before, errs_before, 0);

        flits_before = chk_flits;
        errs_before = total_errors();
        write_flow(4'd6);
        drain();
        finish_test(2, "single write", flits_before, errs_before, 1);

        flits_before = chk_flits;
        errs_before = total_errors();
        for (int i = 0; i < `NUM_FLOWS; i++) begin
            write_flow(`FLOWID_W'(i));
        end
        drain();
        finish_test(3, "burst of all flows", flits_before, errs_before, `NUM_FLOWS);

        flits_before = chk_flits;
        errs_before = total_errors();
        rdy_random = 1'b1;
        for (int i = 0; i < `NUM_FLOWS; i++) begin
            write_flow(`FLOWID_W'(i * 7));  // scrambled order
        end
        drain();
        finish_test(4, "random back-pressure", flits_before, errs_before, `NUM_FLOWS);

        // flow 5 parks in the interface while flow 9 is rewritten behind it
        flits_before = chk_flits;
        errs_before = total_errors();
        next_edge();
        noc_rdy <= 1'b0;
        write_flow(4'd5);
        do begin
            next_edge();
            @(negedge clk);
        end while (!noc_val);
        write_flow(4'd9);
        write_flow(4'd9);
        repeat (6) next_edge();
        noc_rdy <= 1'b1;
        drain();
        finish_test(5, "rewrite while stalled", flits_before, errs_before, 2);

        $display("tests 5, flits %0d, errors %0d", chk_flits, total_errors());
        if (total_errors() == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+rtl
rtl/tcp_tx_pkg.sv
rtl/tcp_tx_flow_table.sv
rtl/tcp_tx_poller.sv
rtl/tcp_tx_msg_noc_if_out_ctrl.sv
rtl/tcp_tx_msg_noc_if_out_datap.sv
rtl/tcp_tx_msg_tile.sv
tb/tcp_tx_msg_checker.sv
tb/tcp_tx_msg_tb.sv

// File: Makefile
TOP = tcp_tx_msg_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing -f all.f --top-module $(TOP) -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
